//--- Makefile
# Verilator build and run of the AHB-Lite fabric testbench

VERILATOR ?= verilator
TOP       ?= ahbLiteFabricTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/ahbLite_defs.svh
`ifndef AHBLITE_DEFS_SVH
`define AHBLITE_DEFS_SVH

// Address map ------------------------------------------------
`define AHB_RAM_REGION      4'h0        // hAddr[31:28] for block RAM
`define AHB_TIMER_REGION    4'h4        // hAddr[31:28] for timer

`define AHB_RAM_WORD_BITS   8           // 256 words of 32 bits

// Slave slots ------------------------------------------------
`define AHB_SLAVE_COUNT     3           // RAM, timer, default
`define SLV_RAM             0
`define SLV_TIMER           1
`define SLV_DEFAULT         2           // Catches unmapped regions

// Timer register offsets, hAddr[3:0]
`define TIMER_CTRL_OFS      4'h0
`define TIMER_RELOAD_OFS    4'h4
`define TIMER_COUNT_OFS     4'h8
`define TIMER_STATUS_OFS    4'hC

// HTRANS encodings, SEQ and BUSY unused
`define HTRANS_IDLE         2'b00
`define HTRANS_NONSEQ       2'b10

`endif

//--- rtl/ahbLiteBlockRam.sv
`timescale 1ns/100ps
`include "ahbLite_defs.svh"

module ahbLiteBlockRam (
    input  logic                HCLK,
    input  logic                rstN,
    input  logic                hSel,
    input  ahbLitePkg::hAddrT   hAddr,
    input  ahbLitePkg::hTransT  hTrans,
    input  logic                hWrite,
    input  ahbLitePkg::hSizeT   hSize,
    input  ahbLitePkg::hDataT   hWData,
    input  logic                hReady,
    output logic                hReadyOut,
    output logic                hResp,
    output ahbLitePkg::hDataT   hRData
);
    import ahbLitePkg::*;

    localparam int Depth = 2 ** `AHB_RAM_WORD_BITS;

    hDataT                         mem [Depth];         // Word storage
    logic [`AHB_RAM_WORD_BITS-1:0] wordAddr;            // Address-phase word index
    logic [`AHB_RAM_WORD_BITS-1:0] wrAddr;              // Pending write word
    logic [3:0]                    laneMask;            // Address-phase byte lanes
    logic [3:0]                    wrMask;              // Pending write lanes
    logic                          wrPend;              // Write in data phase
    logic                          accept;
    logic                          fwdHit;              // Read hits pending write
    hDataT                         rdData;

    assign accept   = hSel && hReady && (hTrans == `HTRANS_NONSEQ);
    assign wordAddr = hAddr[`AHB_RAM_WORD_BITS+1:2];
    assign fwdHit   = wrPend && (wrAddr == wordAddr);

    // Byte lanes from size and low address bits
    always_comb begin
        case (hSize)
            3'd0:    laneMask = 4'b0001 << hAddr[1:0];  // Byte
            3'd1:    laneMask = hAddr[1] ? 4'b1100 : 4'b0011; // Halfword
            default: laneMask = 4'b1111;                // Word
        endcase
    end

    // Address phase ----------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!rstN)
            wrPend <= 1'b0;
        else if (hReady)
            wrPend <= accept && hWrite;                 // Write owns next data phase
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            wrAddr <= wordAddr;
            wrMask <= laneMask;
        end
    end

    // Synchronous read with forwarding of the lanes being written
    always_ff @(posedge HCLK) begin
        if (accept) begin
            for (int i = 0; i < 4; i++) begin
                if (fwdHit && wrMask[i])
                    rdData[i*8 +: 8] <= hWData[i*8 +: 8];    // Newest data wins
                else
                    rdData[i*8 +: 8] <= mem[wordAddr][i*8 +: 8];
            end
        end
    end

    // Data phase, merged lane write at its last edge
    always_ff @(posedge HCLK) begin
        if (wrPend && hReady) begin
            for (int i = 0; i < 4; i++) begin
                if (wrMask[i])
                    mem[wrAddr][i*8 +: 8] <= hWData[i*8 +: 8];
            end
        end
    end

    assign hRData    = rdData;
    assign hReadyOut = 1'b1;                            // Zero wait states
    assign hResp     = 1'b0;                            // Always OKAY

endmodule

//--- rtl/ahbLiteDecoder.sv
`timescale 1ns/100ps
`include "ahbLite_defs.svh"

// Address decoder ---------------------------------------------
// Purely combinational, one slot raised per address
module ahbLiteDecoder (
    input  ahbLitePkg::hAddrT    hAddr,
    output ahbLitePkg::slaveSelT hSel
);

    logic [3:0] region;                                 // Top nibble of address

    assign region = hAddr[31:28];

    always_comb begin
        hSel = '0;                                      // Start with nothing selected
        case (region)
            `AHB_RAM_REGION: begin
                hSel[`SLV_RAM] = 1'b1;                  // Block RAM
            end
            `AHB_TIMER_REGION: begin
                hSel[`SLV_TIMER] = 1'b1;                // Countdown timer
            end
            default: begin
                hSel[`SLV_DEFAULT] = 1'b1;              // Unmapped, error slot
            end
        endcase
    end

    // Low address bits are left to the subordinates
    // so no other part of hAddr is examined here

endmodule

//--- rtl/ahbLiteFabric.sv
`timescale 1ns/100ps
`include "ahbLite_defs.svh"

module ahbLiteFabric (
    input  logic                HCLK,
    input  logic                rstN,
    input  ahbLitePkg::hAddrT   hAddr,
    input  ahbLitePkg::hTransT  hTrans,
    input  logic                hWrite,
    input  ahbLitePkg::hSizeT   hSize,
    input  ahbLitePkg::hDataT   hWData,
    output logic                hReady,
    output logic                hResp,
    output ahbLitePkg::hDataT   hRData,
    output logic                hIrq
);
    import ahbLitePkg::*;

    slaveSelT hSel;                                     // Address-phase select
    logic     ramReadyOut;
    logic     ramResp;
    hDataT    ramRData;
    logic     tmrReadyOut;
    logic     tmrResp;
    hDataT    tmrRData;

    // Decoder ----------------------------------------------------
    ahbLiteDecoder uDecoder (
        .hAddr          (hAddr),
        .hSel           (hSel)
    );

    // Slave mux and default subordinate --------------------------
    ahbLiteSlaveMux uSlaveMux (
        .HCLK           (HCLK),
        .rstN           (rstN),
        .hSel           (hSel),
        .hTrans         (hTrans),
        .ramReadyOut    (ramReadyOut),
        .ramResp        (ramResp),
        .ramRData       (ramRData),
        .tmrReadyOut    (tmrReadyOut),
        .tmrResp        (tmrResp),
        .tmrRData       (tmrRData),
        .hReady         (hReady),                       // Shared bus ready
        .hResp          (hResp),
        .hRData         (hRData)
    );

    // Subordinates -----------------------------------------------
    ahbLiteBlockRam uBlockRam (
        .HCLK           (HCLK),
        .rstN           (rstN),
        .hSel           (hSel[`SLV_RAM]),
        .hAddr          (hAddr),
        .hTrans         (hTrans),
        .hWrite         (hWrite),
        .hSize          (hSize),
        .hWData         (hWData),
        .hReady         (hReady),
        .hReadyOut      (ramReadyOut),
        .hResp          (ramResp),
        .hRData         (ramRData)
    );

    ahbLiteTimer uTimer (
        .HCLK           (HCLK),
        .rstN           (rstN),
        .hSel           (hSel[`SLV_TIMER]),
        .hAddr          (hAddr),
        .hTrans         (hTrans),
        .hWrite         (hWrite),
        .hWData         (hWData),
        .hReady         (hReady),
        .hReadyOut      (tmrReadyOut),
        .hResp          (tmrResp),
        .hRData         (tmrRData),
        .hIrq           (hIrq)                          // Timer interrupt out
    );

endmodule

//--- rtl/ahbLitePkg.sv
`include "ahbLite_defs.svh"

package ahbLitePkg;

    // Bus vectors ------------------------------------------------
    typedef logic [31:0] hAddrT;                        // HADDR
    typedef logic [31:0] hDataT;                        // HWDATA / HRDATA
    typedef logic [2:0]  hSizeT;                        // HSIZE
    typedef logic [1:0]  hTransT;                       // HTRANS

    typedef logic [`AHB_SLAVE_COUNT-1:0] slaveSelT;     // One-hot HSEL

    // Default subordinate FSM
    typedef enum logic [1:0] {
        ERR_IDLE,                                       // Idle, OKAY response
        ERR_FIRST,                                      // ERROR, hReady low
        ERR_SECOND                                      // ERROR, hReady high
    } errStateT;

    // Timer access FSM
    typedef enum logic [1:0] {
        ACC_IDLE,                                       // No access pending
        ACC_WAIT,                                       // Wait state, regs touched here
        ACC_DONE                                        // Last data cycle
    } tmrAccStateT;

endpackage

//--- rtl/ahbLiteSlaveMux.sv
`timescale 1ns/100ps
`include "ahbLite_defs.svh"

module ahbLiteSlaveMux (
    input  logic                 HCLK,
    input  logic                 rstN,
    input  ahbLitePkg::slaveSelT hSel,
    input  ahbLitePkg::hTransT   hTrans,
    input  logic                 ramReadyOut,
    input  logic                 ramResp,
    input  ahbLitePkg::hDataT    ramRData,
    input  logic                 tmrReadyOut,
    input  logic                 tmrResp,
    input  ahbLitePkg::hDataT    tmrRData,
    output logic                 hReady,
    output logic                 hResp,
    output ahbLitePkg::hDataT    hRData
);
    import ahbLitePkg::*;

    slaveSelT dataSel;                                  // Slot owning the data phase
    errStateT errState;
    logic     defStart;                                 // NONSEQ to unmapped region
    logic     defReadyOut;
    logic     defResp;

    // Data-phase select ------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!rstN)
            dataSel <= '0;                              // No owner, bus reads OKAY
        else if (hReady)
            dataSel <= hSel;                            // Advance with the pipeline
    end

    // Default subordinate ----------------------------------------
    assign defStart = hReady && hSel[`SLV_DEFAULT] && (hTrans == `HTRANS_NONSEQ);

    always_ff @(posedge HCLK) begin
        if (!rstN)
            errState <= ERR_IDLE;
        else begin
            case (errState)
                ERR_FIRST: errState <= ERR_SECOND;      // Always two cycles
                default:   errState <= defStart ? ERR_FIRST : ERR_IDLE;
            endcase
        end
    end

    assign defReadyOut = (errState != ERR_FIRST);       // Stall in first ERROR cycle
    assign defResp     = (errState != ERR_IDLE);        // ERROR in both cycles

    // Response routing, idle bus answers OKAY with hReady high
    always_comb begin
        hReady = 1'b1;
        hResp  = 1'b0;
        hRData = '0;
        if (dataSel[`SLV_RAM]) begin
            hReady = ramReadyOut;
            hResp  = ramResp;
            hRData = ramRData;
        end else if (dataSel[`SLV_TIMER]) begin
            hReady = tmrReadyOut;
            hResp  = tmrResp;
            hRData = tmrRData;
        end else if (dataSel[`SLV_DEFAULT]) begin
            hReady = defReadyOut;
            hResp  = defResp;                           // Read data stays zero
        end
    end

endmodule

//--- rtl/ahbLiteTimer.sv
`timescale 1ns/100ps
`include "ahbLite_defs.svh"

module ahbLiteTimer (
    input  logic                HCLK,
    input  logic                rstN,
    input  logic                hSel,
    input  ahbLitePkg::hAddrT   hAddr,
    input  ahbLitePkg::hTransT  hTrans,
    input  logic                hWrite,
    input  ahbLitePkg::hDataT   hWData,
    input  logic                hReady,
    output logic                hReadyOut,
    output logic                hResp,
    output ahbLitePkg::hDataT   hRData,
    output logic                hIrq
);
    import ahbLitePkg::*;

    tmrAccStateT accState;
    logic        accept;
    logic        accWrite;                              // Captured hWrite
    logic [3:0]  regOfs;                                // Captured register offset
    logic        regWr;                                 // Register write this cycle
    logic        ctrlEn;                                // CTRL bit 0
    hDataT       reloadVal;
    hDataT       countVal;
    logic        statusIrq;                             // STATUS bit 0
    hDataT       rdData;

    assign accept = hSel && hReady && (hTrans == `HTRANS_NONSEQ);
    assign regWr  = (accState == ACC_WAIT) && accWrite;

    // Access FSM -------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            accState <= ACC_IDLE;
            accWrite <= 1'b0;
            regOfs   <= '0;
        end else begin
            case (accState)
                ACC_WAIT: accState <= ACC_DONE;         // One wait state
                default:  accState <= accept ? ACC_WAIT : ACC_IDLE;
            endcase
            if (accept) begin
                accWrite <= hWrite;
                regOfs   <= hAddr[3:0];
            end
        end
    end

    // Register read, sampled in the wait state
    always_ff @(posedge HCLK) begin
        if (accState == ACC_WAIT) begin
            case (regOfs)
                `TIMER_CTRL_OFS:   rdData <= {31'b0, ctrlEn};
                `TIMER_RELOAD_OFS: rdData <= reloadVal;
                `TIMER_COUNT_OFS:  rdData <= countVal;
                `TIMER_STATUS_OFS: rdData <= {31'b0, statusIrq};
                default:           rdData <= '0;        // Unused offsets read zero
            endcase
        end
    end

    // Registers and countdown ------------------------------------
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            ctrlEn    <= 1'b0;
            reloadVal <= '0;
            countVal  <= '0;
            statusIrq <= 1'b0;
        end else begin
            if (regWr && regOfs == `TIMER_CTRL_OFS)
                ctrlEn <= hWData[0];
            if (regWr && regOfs == `TIMER_RELOAD_OFS)
                reloadVal <= hWData;
            if (regWr && regOfs == `TIMER_STATUS_OFS && hWData[0])
                statusIrq <= 1'b0;                      // Write one to clear
            if (ctrlEn) begin
                countVal <= (countVal == '0) ? reloadVal : countVal - 1'b1;
                if (countVal == 32'd1)
                    statusIrq <= 1'b1;                  // Set beats clear
            end
        end
    end

    assign hReadyOut = (accState != ACC_WAIT);          // Low in first data cycle
    assign hResp     = 1'b0;
    assign hRData    = rdData;
    assign hIrq      = statusIrq;

endmodule

//--- sim.f
+incdir+include
rtl/ahbLitePkg.sv
rtl/ahbLiteDecoder.sv
rtl/ahbLiteSlaveMux.sv
rtl/ahbLiteBlockRam.sv
rtl/ahbLiteTimer.sv
rtl/ahbLiteFabric.sv
tests/ahbLiteFabric_sva.sv
tests/ahbLiteFabricTb.sv

//--- tests/ahbLiteFabricTb.sv
`timescale 1ns/100ps
`include "ahbLite_defs.svh"

module ahbLiteFabricTb;
    import ahbLitePkg::*;

    localparam int    ReadyTimeout = 20;                // Cycles allowed per wait
    localparam int    TimerReload  = 20;
    localparam hAddrT TimerBase    = 32'h4000_0000;
    localparam hAddrT BadAddr      = 32'h8000_0010;     // Region 0x8, unmapped

    logic   HCLK;
    logic   rstN;
    hAddrT  hAddr;
    hTransT hTrans;
    logic   hWrite;
    hSizeT  hSize;
    hDataT  hWData;
    logic   hReady;
    logic   hResp;
    hDataT  hRData;
    logic   hIrq;

    hDataT  shadow [16];                                // Reference copy of RAM window
    string  nameQ [$];                                  // Completed reads to compare
    hDataT  expQ [$];
    hDataT  actQ [$];
    integer seed = 32'h3614;
    int     errCount = 0;
    int     testErrBase = 0;
    int     testCount = 0;
    int     testFailCount = 0;
    string  testName = "none";

    ahbLiteFabric dut0 (
        .HCLK   (HCLK),
        .rstN   (rstN),
        .hAddr  (hAddr),
        .hTrans (hTrans),
        .hWrite (hWrite),
        .hSize  (hSize),
        .hWData (hWData),
        .hReady (hReady),
        .hResp  (hResp),
        .hRData (hRData),
        .hIrq   (hIrq)
    );

    initial begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;                        // 100 MHz
    end

    // Reference model --------------------------------------------
    function automatic hDataT refMerge(hDataT oldWord, hAddrT addr, hSizeT size, hDataT data);
        hDataT merged;
        logic  laneOn;
        merged = oldWord;
        for (int b = 0; b < 4; b++) begin
            case (size)
                3'd0:    laneOn = (b == addr[1:0]);     // Single byte lane
                3'd1:    laneOn = ((b / 2) == addr[1]); // Lower or upper half
                default: laneOn = 1'b1;
            endcase
            if (laneOn)
                merged[8*b +: 8] = data[8*b +: 8];
        end
        return merged;
    endfunction

    task automatic abortRun(input string what);
        $display("Timeout: gave up waiting for %s", what);
        $display("tests failed");
        $finish;
    endtask

    // Bus tasks, all entered and left 1 ns after a rising edge ---
    task automatic waitReady(input string what, output hDataT rData, output logic resp);
        int cycles;
        cycles = 0;
        @(negedge HCLK);                                // hReady settled mid-cycle
        while (!hReady) begin
            cycles++;
            if (cycles > ReadyTimeout)
                abortRun(what);
            @(negedge HCLK);
        end
        rData = hRData;
        resp  = hResp;
        @(posedge HCLK);                                // Edge that completes the phase
        #1;
    endtask

    task automatic driveIdle();
        hAddr  = '0;
        hTrans = `HTRANS_IDLE;
        hWrite = 1'b0;
        hSize  = 3'd2;
    endtask

    task automatic driveAddr(input hAddrT addr, input hSizeT size, input logic write);
        hAddr  = addr;
        hTrans = `HTRANS_NONSEQ;
        hWrite = write;
        hSize  = size;
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        assert (actual === expected)
        else begin
            $display("[FAIL] %s: %s expected %b, actual %b", testName, what, expected, actual);
            errCount++;
        end
    endtask

    task automatic ahbWrite(input hAddrT addr, input hSizeT size, input hDataT data);
        hDataT rData;
        logic  resp;
        driveAddr(addr, size, 1'b1);
        waitReady("write address phase", rData, resp);
        driveIdle();
        hWData = data;                                  // Valid for the whole data phase
        waitReady("write data phase", rData, resp);
        checkFlag("write hResp", 1'b0, resp);
    endtask

    task automatic ahbRead(input hAddrT addr, input hSizeT size, output hDataT data);
        hDataT rData;
        logic  resp;
        driveAddr(addr, size, 1'b0);
        waitReady("read address phase", rData, resp);
        driveIdle();
        waitReady("read data phase", data, resp);
        checkFlag("read hResp", 1'b0, resp);
    endtask

    // Write data phase overlaps the read address phase
    task automatic ahbPipe(input hAddrT addr, input hSizeT size, input hDataT data,
                           output hDataT rdData);
        hDataT rData;
        logic  resp;
        driveAddr(addr, size, 1'b1);
        waitReady("pipelined write address", rData, resp);
        hWData = data;
        driveAddr({addr[31:2], 2'b00}, 3'd2, 1'b0);
        waitReady("pipelined read address", rData, resp);
        driveIdle();
        waitReady("pipelined read data", rdData, resp);
    endtask

    task automatic queueCheck(input hDataT expected, input hDataT actual);
        nameQ.push_back(testName);
        expQ.push_back(expected);
        actQ.push_back(actual);
    endtask

    task automatic ramWrite(input hAddrT addr, input hSizeT size, input hDataT data);
        shadow[addr[5:2]] = refMerge(shadow[addr[5:2]], addr, size, data);
        ahbWrite(addr, size, data);
    endtask

    task automatic ramCheck(input hAddrT addr, input hSizeT size);
        hDataT rd;
        ahbRead(addr, size, rd);
        queueCheck(shadow[addr[5:2]], rd);              // Whole word comes back
    endtask

    task automatic finishTest();
        int waits;
        int errs;
        waits = 0;
        while (actQ.size() != 0) begin
            waits++;
            if (waits > ReadyTimeout)
                abortRun("read comparisons to finish");
            @(posedge HCLK);
            #1;
        end
        errs = errCount - testErrBase;
        testCount++;
        if (errs != 0) begin
            testFailCount++;
            $display("test %s: %0d errors", testName, errs);
        end else begin
            $display("test %s: ok", testName);
        end
        testErrBase = errCount;
    endtask

    // Comparison of completed reads ------------------------------
    always @(negedge HCLK) begin
        string name;
        hDataT exp;
        hDataT act;
        while (actQ.size() != 0) begin
            name = nameQ.pop_front();
            exp  = expQ.pop_front();
            act  = actQ.pop_front();
            assert (act === exp)
            else begin
                $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
                errCount++;
            end
        end
    end

    // Test sequence ----------------------------------------------
    initial begin
        hDataT rd;
        hDataT data;
        hAddrT addr;
        hSizeT size;
        logic  resp;
        int    cycles;
        rstN   = 1'b0;
        hWData = '0;
        driveIdle();
        repeat (16) @(posedge HCLK);
        #1;
        rstN = 1'b1;

        testName = "ramWords";
        for (int i = 0; i < 16; i++) begin
            data = $random(seed);
            ramWrite(hAddrT'(i * 4), 3'd2, data);
        end
        for (int i = 0; i < 16; i++)
            ramCheck(hAddrT'(i * 4), 3'd2);
        finishTest();

        testName = "byteLanes";
        for (int ofs = 0; ofs < 4; ofs++) begin
            addr = hAddrT'(32'h14 + ofs);               // Every byte of word 5
            data = $random(seed);
            ramWrite(addr, 3'd0, data);
            ramCheck(addr, 3'd0);
        end
        for (int ofs = 0; ofs < 4; ofs += 2) begin
            addr = hAddrT'(32'h18 + ofs);               // Both halves of word 6
            data = $random(seed);
            ramWrite(addr, 3'd1, data);
            ramCheck(addr, 3'd1);
        end
        finishTest();

        testName = "pipeline";
        for (int i = 0; i < 4; i++) begin
            size = hSizeT'(i % 3);
            addr = hAddrT'(32'h20 + 4 * i + ((size == 3'd0) ? 3 : (size == 3'd1) ? 2 : 0));
            data = $random(seed);
            shadow[addr[5:2]] = refMerge(shadow[addr[5:2]], addr, size, data);
            ahbPipe(addr, size, data, rd);
            queueCheck(shadow[addr[5:2]], rd);
        end
        finishTest();

        testName = "timer";
        ahbWrite(TimerBase + `TIMER_RELOAD_OFS, 3'd2, TimerReload);
        ahbRead(TimerBase + `TIMER_RELOAD_OFS, 3'd2, rd);
        queueCheck(TimerReload, rd);
        ahbWrite(TimerBase + `TIMER_CTRL_OFS, 3'd2, 32'd1);
        cycles = 0;
        @(negedge HCLK);
        while (!hIrq) begin
            cycles++;
            if (cycles > TimerReload + 4)
                abortRun("timer interrupt");
            @(negedge HCLK);
        end
        @(posedge HCLK);
        #1;
        ahbRead(TimerBase + `TIMER_STATUS_OFS, 3'd2, rd);
        queueCheck(32'd1, rd);
        ahbRead(TimerBase + `TIMER_COUNT_OFS, 3'd2, rd);
        assert (rd <= TimerReload)
        else begin
            $display("[FAIL] %s: count expected at most %0d, actual %0d", testName,
                     TimerReload, rd);
            errCount++;
        end
        ahbWrite(TimerBase + `TIMER_CTRL_OFS, 3'd2, 32'd0);   // Stop before clearing
        ahbWrite(TimerBase + `TIMER_STATUS_OFS, 3'd2, 32'd1);
        checkFlag("hIrq after clear", 1'b0, hIrq);
        ahbRead(TimerBase + `TIMER_STATUS_OFS, 3'd2, rd);
        queueCheck(32'd0, rd);
        finishTest();

        testName = "errorResp";
        driveAddr(BadAddr, 3'd2, 1'b0);
        waitReady("unmapped address phase", rd, resp);
        driveIdle();
        @(negedge HCLK);                                // First ERROR cycle
        checkFlag("hResp cycle 1", 1'b1, hResp);
        checkFlag("hReady cycle 1", 1'b0, hReady);
        @(negedge HCLK);                                // Second ERROR cycle
        checkFlag("hResp cycle 2", 1'b1, hResp);
        checkFlag("hReady cycle 2", 1'b1, hReady);
        @(posedge HCLK);
        #1;
        ramCheck(32'h0, 3'd2);                          // Bus still usable
        finishTest();

        testName = "randomMix";
        for (int n = 0; n < 64; n++) begin
            size = hSizeT'($unsigned($random(seed)) % 3);
            addr = hAddrT'($random(seed)) & 32'h0000_003F;
            if (size == 3'd1)
                addr[0] = 1'b0;
            if (size == 3'd2)
                addr[1:0] = 2'b00;
            data = $random(seed);
            if ($random(seed) & 1)
                ramWrite(addr, size, data);
            else
                ramCheck(addr, size);
        end
        finishTest();

        $display("summary: %0d tests, %0d with errors, %0d check errors",
                 testCount, testFailCount, errCount);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tests/ahbLiteFabric_sva.sv
`timescale 1ns/100ps

module ahbLiteFabric_sva (
    input logic HCLK,
    input logic rstN,
    input logic hReady,
    input logic hResp,
    input logic hIrq
);

    // ERROR response ---------------------------------------------
    property errorSecondCycle;
        @(posedge HCLK) disable iff (!rstN)
            (hResp && !hReady) |=> (hResp && hReady);
    endproperty

    errorTwoCycles: assert property (errorSecondCycle)
        else $error("ERROR cycle with hReady low not followed by ERROR with hReady high");

    // Reset behaviour --------------------------------------------
    readyAfterReset: assert property (@(posedge HCLK) $rose(rstN) |-> hReady)
        else $error("hReady low in first cycle after reset");

    // Second reset edge onward, registers are cleared by then
    irqLowInReset: assert property (@(posedge HCLK) (!rstN && $past(!rstN)) |-> !hIrq)
        else $error("hIrq high while reset is active");

endmodule

bind ahbLiteFabric ahbLiteFabric_sva uSva (
    .HCLK   (HCLK),
    .rstN   (rstN),
    .hReady (hReady),
    .hResp  (hResp),
    .hIrq   (hIrq)
);
